//--- hw/rs_cfg.svh
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// --------------------
// reservation station sizing

// entries held by each of the two banks
`define RS_ENTRIES 8

// physical register tag width
`define RS_TAG_W 8

// external completion ports (mul, div, load, branch, csr share these)
`define RS_WAKE_PORTS 4

// --------------------

`endif

//--- hw/rs_pkg.sv
`default_nettype none

`include "rs_cfg.svh"

package rs_pkg;

  // second source is either a physical tag or an immediate, src2_is_imm decides
  typedef union packed {
    struct packed {
      logic [31-`RS_TAG_W:0] upper;  // don't care when read as a tag
      logic [`RS_TAG_W-1:0]  tag;
    } phys;
    logic [31:0] imm;
  } rs_src2_u;

  // --------------------
  // dispatch from rename
  typedef struct packed {
    logic [31:0]          inst_num;
    logic [31:0]          pc;
    logic [`RS_TAG_W-1:0] rd;
    logic [3:0]           alu_op;
    logic                 src1_is_pc;
    logic                 src2_is_imm;
    logic [`RS_TAG_W-1:0] src1;
    logic                 src1_ready;
    rs_src2_u             src2;
    logic                 src2_ready;
  } rs_dispatch_t;

  // completion broadcast
  typedef struct packed {
    logic                 valid;
    logic [`RS_TAG_W-1:0] tag;
  } rs_wakeup_t;

  // --------------------
  // issue toward the ALU, no ready bits left by now
  typedef struct packed {
    logic                 valid;
    logic [31:0]          inst_num;
    logic [31:0]          pc;
    logic [`RS_TAG_W-1:0] rd;
    logic [3:0]           alu_op;
    logic                 src1_is_pc;
    logic                 src2_is_imm;
    logic [`RS_TAG_W-1:0] src1;
    rs_src2_u             src2;
  } rs_issue_t;

endpackage

`default_nettype wire

//--- hw/rs_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "rs_cfg.svh"

module rs_bank (
  input  wire logic                                       clk,
  input  wire logic                                       rst,
  input  wire logic                                       flush,
  input  wire logic                                       wr_en,
  input  rs_pkg::rs_dispatch_t                            dispatch,
  input  rs_pkg::rs_wakeup_t [`RS_WAKE_PORTS:0]           wakeup,
  input  wire logic                                       grant,
  output rs_pkg::rs_issue_t                               candidate,
  output logic                                            full
);

  localparam int IDX_W = $clog2(`RS_ENTRIES);

  logic [`RS_ENTRIES-1:0] occupied;
  logic [`RS_ENTRIES-1:0] rdy1;  // stored operand state
  logic [`RS_ENTRIES-1:0] rdy2;
  logic [`RS_ENTRIES-1:0] ready1_now;  // stored state or a wakeup this cycle
  logic [`RS_ENTRIES-1:0] ready2_now;

  rs_pkg::rs_dispatch_t entry [`RS_ENTRIES];

  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] sel_idx;
  logic             sel_valid;
  logic             disp_rdy1;
  logic             disp_rdy2;

  // true when any valid broadcast carries this tag
  function automatic logic tag_woken(
    input rs_pkg::rs_wakeup_t [`RS_WAKE_PORTS:0] wk,
    input logic [`RS_TAG_W-1:0]                  tag
  );
    logic hit;
    hit = 1'b0;
    for (int p = 0; p <= `RS_WAKE_PORTS; p++) begin
      if (wk[p].valid && wk[p].tag == tag) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // --------------------
  // wakeup compare

  always_comb begin
    for (int i = 0; i < `RS_ENTRIES; i++) begin
      ready1_now[i] = rdy1[i] | tag_woken(wakeup, entry[i].src1);
      ready2_now[i] = rdy2[i] | tag_woken(wakeup, entry[i].src2.phys.tag);
    end
  end

  // dispatch bypass, an immediate never waits on src2
  assign disp_rdy1 = dispatch.src1_ready | tag_woken(wakeup, dispatch.src1);
  assign disp_rdy2 = dispatch.src2_ready | dispatch.src2_is_imm |
                     tag_woken(wakeup, dispatch.src2.phys.tag);

  // --------------------
  // lowest free slot and lowest ready slot

  always_comb begin
    free_idx  = '0;
    sel_idx   = '0;
    sel_valid = 1'b0;
    // walk downward so the lowest index is the one left standing
    for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
      if (!occupied[i]) begin
        free_idx = IDX_W'(i);
      end
      if (occupied[i] && ready1_now[i] && ready2_now[i]) begin
        sel_idx   = IDX_W'(i);
        sel_valid = 1'b1;
      end
    end
  end

  assign full = &occupied;

  // --------------------
  // entry state

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      occupied <= '0;
    end else begin
      for (int i = 0; i < `RS_ENTRIES; i++) begin
        if (occupied[i]) begin
          rdy1[i] <= ready1_now[i];
          rdy2[i] <= ready2_now[i];
        end
      end
      if (grant && sel_valid) begin
        occupied[sel_idx] <= 1'b0;  // the arbiter took it this cycle
      end
      if (wr_en) begin
        occupied[free_idx] <= 1'b1;
        rdy1[free_idx]     <= disp_rdy1;
        rdy2[free_idx]     <= disp_rdy2;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      entry[free_idx] <= dispatch;
    end
  end

  // --------------------
  // candidate toward the arbiter

  always_comb begin
    candidate = '{
      valid:       sel_valid,
      inst_num:    entry[sel_idx].inst_num,
      pc:          entry[sel_idx].pc,
      rd:          entry[sel_idx].rd,
      alu_op:      entry[sel_idx].alu_op,
      src1_is_pc:  entry[sel_idx].src1_is_pc,
      src2_is_imm: entry[sel_idx].src2_is_imm,
      src1:        entry[sel_idx].src1,
      src2:        entry[sel_idx].src2
    };
  end

endmodule

`default_nettype wire

//--- hw/issue_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module issue_arbiter (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        flush,
  input  wire logic        dispatch_valid,
  input  wire logic        dispatch_parity,
  input  wire logic [1:0]  bank_full,
  input  rs_pkg::rs_issue_t cand0,
  input  rs_pkg::rs_issue_t cand1,
  output logic             dispatch_ready,
  output logic [1:0]       wr_en,
  output logic [1:0]       grant,
  output rs_pkg::rs_issue_t issue_out
);

  logic              accept;
  logic              pick1;
  rs_pkg::rs_issue_t winner;

  // --------------------
  // dispatch steering, even numbers to bank 0 and odd to bank 1

  assign dispatch_ready = !bank_full[dispatch_parity];
  assign accept         = dispatch_valid && dispatch_ready;
  assign wr_en          = {accept && dispatch_parity, accept && !dispatch_parity};

  // --------------------
  // age compare

  // bank 1 only wins with the strictly smaller number
  assign pick1 = cand1.valid && (!cand0.valid || cand1.inst_num < cand0.inst_num);
  assign winner = pick1 ? cand1 : cand0;
  assign grant  = {pick1, cand0.valid && !pick1};

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      issue_out.valid <= 1'b0;
    end else begin
      issue_out <= winner;  // valid comes along from the candidate
    end
  end

endmodule

`default_nettype wire

//--- hw/alu_issue_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rs_cfg.svh"

module alu_issue_unit (
  input  wire logic                                clk,
  input  wire logic                                rst,
  input  wire logic                                flush,
  input  wire logic                                dispatch_valid,
  input  rs_pkg::rs_dispatch_t                     dispatch,
  output logic                                     dispatch_ready,
  input  rs_pkg::rs_wakeup_t [`RS_WAKE_PORTS-1:0]  ext_wakeup,
  output rs_pkg::rs_issue_t                        issue_out
);

  rs_pkg::rs_wakeup_t [`RS_WAKE_PORTS:0] wakeup;
  rs_pkg::rs_issue_t                     cand0;
  rs_pkg::rs_issue_t                     cand1;
  logic [1:0]                            bank_full;
  logic [1:0]                            wr_en;
  logic [1:0]                            grant;

  // --------------------
  // wakeup bus, the ALU result lands one cycle after issue so rd is broadcast as is
  assign wakeup[`RS_WAKE_PORTS-1:0] = ext_wakeup;
  assign wakeup[`RS_WAKE_PORTS]     = '{valid: issue_out.valid, tag: issue_out.rd};

  rs_bank bank0_i (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .wr_en     (wr_en[0]),
    .dispatch  (dispatch),
    .wakeup    (wakeup),
    .grant     (grant[0]),
    .candidate (cand0),
    .full      (bank_full[0])
  );

  rs_bank bank1_i (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .wr_en     (wr_en[1]),
    .dispatch  (dispatch),
    .wakeup    (wakeup),
    .grant     (grant[1]),
    .candidate (cand1),
    .full      (bank_full[1])
  );

  issue_arbiter issue_arbiter_i (
    .clk             (clk),
    .rst             (rst),
    .flush           (flush),
    .dispatch_valid  (dispatch_valid),
    .dispatch_parity (dispatch.inst_num[0]),
    .bank_full       (bank_full),
    .cand0           (cand0),
    .cand1           (cand1),
    .dispatch_ready  (dispatch_ready),
    .wr_en           (wr_en),
    .grant           (grant),
    .issue_out       (issue_out)
  );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // reset is held over the first 16 rising edges and dropped on a falling edge
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- dv/issue_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "rs_cfg.svh"

module issue_checker (
  input  wire logic                               clk,
  input  wire logic                               rst,
  input  wire logic                               flush,
  input  wire logic                               dispatch_valid,
  input  rs_pkg::rs_dispatch_t                    dispatch,
  input  wire logic                               dispatch_ready,
  input  rs_pkg::rs_wakeup_t [`RS_WAKE_PORTS-1:0] ext_wakeup,
  input  rs_pkg::rs_issue_t                       issue_out,
  output int                                      value_errs,
  output int                                      other_errs,
  output int                                      pending_cnt
);

  rs_pkg::rs_dispatch_t pend_q[$];  // accepted and not issued yet
  int                   pend_cyc[$];  // edge that accepted each of them
  int                   woken_at [1 << `RS_TAG_W];  // last edge that woke each tag
  int                   cyc = 0;

  initial begin
    value_errs  = 0;
    other_errs  = 0;
    pending_cnt = 0;
    foreach (woken_at[t]) woken_at[t] = -1;
  end

  // an operand counts once it was ready at dispatch or woken at or after that edge
  function automatic logic may_issue(input rs_pkg::rs_dispatch_t d, input int dcyc);
    logic ok1;
    logic ok2;
    ok1 = d.src1_ready || woken_at[d.src1] >= dcyc;
    ok2 = d.src2_ready || d.src2_is_imm || woken_at[d.src2.phys.tag] >= dcyc;
    return ok1 && ok2;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      value_errs++;
      $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // --------------------
  // issue side

  task automatic check_issue();
    int idx;
    rs_pkg::rs_dispatch_t exp;
    idx = -1;
    foreach (pend_q[i]) begin
      if (pend_q[i].inst_num == issue_out.inst_num) idx = i;
    end
    if (idx < 0) begin
      other_errs++;
      $display("t=%0t instruction %0d issued although it is not pending", $time,
               issue_out.inst_num);
      return;
    end
    exp = pend_q[idx];
    compare_field("issue_out.pc", exp.pc, issue_out.pc);
    compare_field("issue_out.rd", 32'(exp.rd), 32'(issue_out.rd));
    compare_field("issue_out.alu_op", 32'(exp.alu_op), 32'(issue_out.alu_op));
    compare_field("issue_out.src1_is_pc", 32'(exp.src1_is_pc), 32'(issue_out.src1_is_pc));
    compare_field("issue_out.src2_is_imm", 32'(exp.src2_is_imm), 32'(issue_out.src2_is_imm));
    compare_field("issue_out.src1", 32'(exp.src1), 32'(issue_out.src1));
    compare_field("issue_out.src2", exp.src2.imm, issue_out.src2.imm);
    // the issue itself happened one edge before this sample
    if (!may_issue(exp, pend_cyc[idx]) || pend_cyc[idx] >= cyc - 1) begin
      other_errs++;
      $display("t=%0t instruction %0d issued before its operands were woken", $time,
               exp.inst_num);
    end
    pend_q.delete(idx);
    pend_cyc.delete(idx);
  endtask

  // a bank is full once RS_ENTRIES of its parity are pending
  task automatic check_ready();
    int   cnt;
    logic exp_ready;
    cnt = 0;
    foreach (pend_q[i]) begin
      if (pend_q[i].inst_num[0] == dispatch.inst_num[0]) cnt++;
    end
    exp_ready = cnt < `RS_ENTRIES;
    if (dispatch_ready !== exp_ready) begin
      value_errs++;
      $display("CHECK FAILED t=%0t dispatch_ready expected %0b got %0b", $time, exp_ready,
               dispatch_ready);
    end
  endtask

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (rst) begin
      pend_q.delete();
      pend_cyc.delete();
    end else begin
      if (issue_out.valid) check_issue();
      if (dispatch_valid) check_ready();
      for (int p = 0; p < `RS_WAKE_PORTS; p++) begin
        if (ext_wakeup[p].valid) woken_at[ext_wakeup[p].tag] = cyc;
      end
      if (issue_out.valid) woken_at[issue_out.rd] = cyc;  // single-cycle ALU result
      if (flush) begin
        pend_q.delete();
        pend_cyc.delete();
      end else if (dispatch_valid && dispatch_ready) begin
        pend_q.push_back(dispatch);
        pend_cyc.push_back(cyc);
      end
    end
    pending_cnt = pend_q.size();
  end

endmodule

`default_nettype wire

//--- dv/alu_issue_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rs_cfg.svh"

module alu_issue_tb;

  localparam int NUM_DISP       = 300;
  localparam int FLUSH_AT       = 150;
  localparam int TIMEOUT_CYCLES = NUM_DISP * 40 + 200;

  logic                                    clk;
  logic                                    rst;
  logic                                    flush;
  logic                                    dispatch_valid;
  logic                                    dispatch_ready;
  rs_pkg::rs_dispatch_t                    dispatch;
  rs_pkg::rs_wakeup_t [`RS_WAKE_PORTS-1:0] ext_wakeup;
  rs_pkg::rs_issue_t                       issue_out;

  int                   value_errs;
  int                   other_errs;
  int                   pending_cnt;
  int                   cycles = 0;
  int                   sent;
  int                   next_num;
  logic                 accepted;
  logic                 flush_done;
  logic [31:0]          rng;
  logic [`RS_TAG_W-1:0] wake_q[$];  // source tags still owed a wakeup

  tb_clock_gen clock_gen_i (.clk(clk), .rst(rst));

  alu_issue_unit alu_issue_unit_i (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .ext_wakeup     (ext_wakeup),
    .issue_out      (issue_out)
  );

  issue_checker checker_i (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .ext_wakeup     (ext_wakeup),
    .issue_out      (issue_out),
    .value_errs     (value_errs),
    .other_errs     (other_errs),
    .pending_cnt    (pending_cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function logic one_in(input logic [31:0] n);
    logic [31:0] r;
    r = next_rand();
    return r % n == 0;
  endfunction

  // --------------------
  // stimulus

  task make_dispatch();
    logic [31:0] r;
    r = next_rand();
    dispatch.inst_num    = 32'(next_num);
    dispatch.pc          = {r[31:2], 2'b00};
    r = next_rand();
    dispatch.rd          = {1'b0, r[`RS_TAG_W-2:0]};  // real tags stay in the lower half
    dispatch.alu_op      = r[11:8];
    dispatch.src1_is_pc  = r[12];
    dispatch.src2_is_imm = r[15:13] < 3'd3;
    dispatch.src1_ready  = r[17:16] == 2'd0;
    dispatch.src2_ready  = r[19:18] == 2'd0 && !dispatch.src2_is_imm;
    r = next_rand();
    dispatch.src1        = {1'b0, r[`RS_TAG_W-2:0]};
    dispatch.src2.imm    = next_rand();
    // an immediate read as a tag lands in the upper half, which no wakeup ever carries
    dispatch.src2.phys.tag[`RS_TAG_W-1] = dispatch.src2_is_imm;
    next_num++;
    dispatch_valid = 1'b1;
  endtask

  task queue_sources();
    if (!dispatch.src1_ready) wake_q.push_back(dispatch.src1);
    if (!dispatch.src2_is_imm && !dispatch.src2_ready) wake_q.push_back(dispatch.src2.phys.tag);
  endtask

  task drive_wakeups();
    logic [31:0] rate;
    rate = (sent >= 60 && sent < 120) ? 32'd16 : 32'd2;  // slow phase lets the banks fill
    for (int p = 0; p < `RS_WAKE_PORTS; p++) begin
      ext_wakeup[p] = '0;
      if (wake_q.size() > 0 && one_in(rate)) begin
        ext_wakeup[p].valid = 1'b1;
        ext_wakeup[p].tag   = wake_q.pop_front();
      end else if (one_in(16)) begin
        ext_wakeup[p].valid = 1'b1;
        ext_wakeup[p].tag   = dispatch.src1;  // lands in the same cycle as the dispatch
      end
    end
  endtask

  initial begin
    dispatch_valid = 1'b0;
    dispatch       = '0;
    ext_wakeup     = '0;
    flush          = 1'b0;
    rng            = 32'h6e0f_836c;
    sent           = 0;
    next_num       = 1;
    flush_done     = 1'b0;
    wait (!rst);
    @(negedge clk);
    while (sent < NUM_DISP) begin
      @(posedge clk);
      accepted = dispatch_valid && dispatch_ready && !flush;
      if (accepted) begin
        queue_sources();
        sent++;
      end
      @(negedge clk);
      flush = 1'b0;
      if (accepted || !dispatch_valid) begin
        if (sent < NUM_DISP && !one_in(4)) begin
          make_dispatch();
        end else begin
          dispatch_valid = 1'b0;
        end
      end
      drive_wakeups();
      if (sent == FLUSH_AT && !flush_done) begin
        flush      = 1'b1;  // the payload on the bus now is dropped and sent again
        flush_done = 1'b1;
      end
    end
    // drain until every owed tag is woken and the station is empty
    while (wake_q.size() > 0 || pending_cnt != 0) begin
      @(negedge clk);
      drive_wakeups();
    end
    ext_wakeup = '0;
    repeat (10) @(negedge clk);
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // --------------------
  // timeout

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d instructions pending and %0d tags unwoken",
               cycles, pending_cnt, wake_q.size());
      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs + 1);
      $display("Verification failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+hw
hw/rs_pkg.sv
hw/rs_bank.sv
hw/issue_arbiter.sv
hw/alu_issue_unit.sv
dv/tb_clock_gen.sv
dv/issue_checker.sv
dv/alu_issue_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module alu_issue_tb \
  -o alu_issue_sim
./obj_dir/alu_issue_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished without failures"
